// ==== Bender.yml ====
package:
  name: axil_pause

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/axil_pause_pkg.sv
      - hdl/axil_if.sv
      - hdl/axil_txn_tracker.sv
      - hdl/axil_pause_fsm.sv
      - hdl/axil_pause_gate.sv
      - hdl/axil_pause.sv

  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/axil_mem_target.sv
      - sim/axil_pause_tb.sv

// ==== hdl/axil_if.sv ====
`timescale 1ns/100ps

interface axil_if;

    // write address channel
    axil_pause_pkg::addr_t aw_addr;
    axil_pause_pkg::prot_t aw_prot;
    logic                  aw_valid;
    logic                  aw_ready;

    // write data channel
    axil_pause_pkg::data_t w_data;
    axil_pause_pkg::strb_t w_strb;
    logic                  w_valid;
    logic                  w_ready;

    // write response channel
    axil_pause_pkg::resp_t b_resp;
    logic                  b_valid;
    logic                  b_ready;

    // read address channel
    axil_pause_pkg::addr_t ar_addr;
    axil_pause_pkg::prot_t ar_prot;
    logic                  ar_valid;
    logic                  ar_ready;

    // read data channel
    axil_pause_pkg::data_t r_data;
    axil_pause_pkg::resp_t r_resp;
    logic                  r_valid;
    logic                  r_ready;

    modport initiator (
        output aw_addr, aw_prot, aw_valid,
        input  aw_ready,
        output w_data, w_strb, w_valid,
        input  w_ready,
        input  b_resp, b_valid,
        output b_ready,
        output ar_addr, ar_prot, ar_valid,
        input  ar_ready,
        input  r_data, r_resp, r_valid,
        output r_ready
    );

    modport target (
        input  aw_addr, aw_prot, aw_valid,
        output aw_ready,
        input  w_data, w_strb, w_valid,
        output w_ready,
        output b_resp, b_valid,
        input  b_ready,
        input  ar_addr, ar_prot, ar_valid,
        output ar_ready,
        output r_data, r_resp, r_valid,
        input  r_ready
    );

endinterface

// ==== hdl/axil_pause.sv ====
`timescale 1ns/100ps

module axil_pause (
    input  logic                  seq,
    input  logic                  rst_n,

    input  logic                  pause_req,
    output logic                  pause_ack,

    // upstream side, towards the initiator
    input  axil_pause_pkg::addr_t s_aw_addr,
    input  axil_pause_pkg::prot_t s_aw_prot,
    input  logic                  s_aw_valid,
    output logic                  s_aw_ready,
    input  axil_pause_pkg::data_t s_w_data,
    input  axil_pause_pkg::strb_t s_w_strb,
    input  logic                  s_w_valid,
    output logic                  s_w_ready,
    output axil_pause_pkg::resp_t s_b_resp,
    output logic                  s_b_valid,
    input  logic                  s_b_ready,
    input  axil_pause_pkg::addr_t s_ar_addr,
    input  axil_pause_pkg::prot_t s_ar_prot,
    input  logic                  s_ar_valid,
    output logic                  s_ar_ready,
    output axil_pause_pkg::data_t s_r_data,
    output axil_pause_pkg::resp_t s_r_resp,
    output logic                  s_r_valid,
    input  logic                  s_r_ready,

    // downstream side, towards the target
    output axil_pause_pkg::addr_t m_aw_addr,
    output axil_pause_pkg::prot_t m_aw_prot,
    output logic                  m_aw_valid,
    input  logic                  m_aw_ready,
    output axil_pause_pkg::data_t m_w_data,
    output axil_pause_pkg::strb_t m_w_strb,
    output logic                  m_w_valid,
    input  logic                  m_w_ready,
    input  axil_pause_pkg::resp_t m_b_resp,
    input  logic                  m_b_valid,
    output logic                  m_b_ready,
    output axil_pause_pkg::addr_t m_ar_addr,
    output axil_pause_pkg::prot_t m_ar_prot,
    output logic                  m_ar_valid,
    input  logic                  m_ar_ready,
    input  axil_pause_pkg::data_t m_r_data,
    input  axil_pause_pkg::resp_t m_r_resp,
    input  logic                  m_r_valid,
    output logic                  m_r_ready
);

    axil_if up_if ();
    axil_if dn_if ();

    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic ar_fire;
    logic r_fire;
    logic write_room;
    logic read_room;
    logic w_owed;
    logic idle;
    logic accept_en;

    assign up_if.aw_addr  = s_aw_addr;
    assign up_if.aw_prot  = s_aw_prot;
    assign up_if.aw_valid = s_aw_valid;
    assign s_aw_ready     = up_if.aw_ready;
    assign up_if.w_data   = s_w_data;
    assign up_if.w_strb   = s_w_strb;
    assign up_if.w_valid  = s_w_valid;
    assign s_w_ready      = up_if.w_ready;
    assign s_b_resp       = up_if.b_resp;
    assign s_b_valid      = up_if.b_valid;
    assign up_if.b_ready  = s_b_ready;
    assign up_if.ar_addr  = s_ar_addr;
    assign up_if.ar_prot  = s_ar_prot;
    assign up_if.ar_valid = s_ar_valid;
    assign s_ar_ready     = up_if.ar_ready;
    assign s_r_data       = up_if.r_data;
    assign s_r_resp       = up_if.r_resp;
    assign s_r_valid      = up_if.r_valid;
    assign up_if.r_ready  = s_r_ready;

    assign m_aw_addr      = dn_if.aw_addr;
    assign m_aw_prot      = dn_if.aw_prot;
    assign m_aw_valid     = dn_if.aw_valid;
    assign dn_if.aw_ready = m_aw_ready;
    assign m_w_data       = dn_if.w_data;
    assign m_w_strb       = dn_if.w_strb;
    assign m_w_valid      = dn_if.w_valid;
    assign dn_if.w_ready  = m_w_ready;
    assign dn_if.b_resp   = m_b_resp;
    assign dn_if.b_valid  = m_b_valid;
    assign m_b_ready      = dn_if.b_ready;
    assign m_ar_addr      = dn_if.ar_addr;
    assign m_ar_prot      = dn_if.ar_prot;
    assign m_ar_valid     = dn_if.ar_valid;
    assign dn_if.ar_ready = m_ar_ready;
    assign dn_if.r_data   = m_r_data;
    assign dn_if.r_resp   = m_r_resp;
    assign dn_if.r_valid  = m_r_valid;
    assign m_r_ready      = dn_if.r_ready;

    // handshakes are counted where they reach the target
    assign aw_fire = dn_if.aw_valid && dn_if.aw_ready;
    assign w_fire  = dn_if.w_valid && dn_if.w_ready;
    assign b_fire  = dn_if.b_valid && dn_if.b_ready;
    assign ar_fire = dn_if.ar_valid && dn_if.ar_ready;
    assign r_fire  = dn_if.r_valid && dn_if.r_ready;

    axil_pause_gate i_gate (
        .up         (up_if.target),
        .dn         (dn_if.initiator),
        .accept_en  (accept_en),
        .write_room (write_room),
        .read_room  (read_room),
        .w_owed     (w_owed)
    );

    axil_txn_tracker i_tracker (
        .seq        (seq),
        .rst_n      (rst_n),
        .aw_fire    (aw_fire),
        .w_fire     (w_fire),
        .b_fire     (b_fire),
        .ar_fire    (ar_fire),
        .r_fire     (r_fire),
        .write_room (write_room),
        .read_room  (read_room),
        .w_owed     (w_owed),
        .idle       (idle)
    );

    axil_pause_fsm i_fsm (
        .seq        (seq),
        .rst_n      (rst_n),
        .pause_req  (pause_req),
        .idle       (idle),
        .pause_ack  (pause_ack),
        .accept_en  (accept_en)
    );

endmodule

// ==== hdl/axil_pause_fsm.sv ====
`timescale 1ns/100ps

module axil_pause_fsm (
    input  logic seq,
    input  logic rst_n,

    input  logic pause_req,
    input  logic idle,

    output logic pause_ack,
    output logic accept_en
);

    axil_pause_pkg::pause_state_e state;
    axil_pause_pkg::pause_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            axil_pause_pkg::RUN: begin
                if (pause_req) begin
                    state_next = axil_pause_pkg::DRAIN;
                end
            end
            axil_pause_pkg::DRAIN: begin
                // a withdrawn request wins over a link that just went idle
                if (!pause_req) begin
                    state_next = axil_pause_pkg::RUN;
                end else if (idle) begin
                    state_next = axil_pause_pkg::PAUSED;
                end
            end
            axil_pause_pkg::PAUSED: begin
                if (!pause_req) begin
                    state_next = axil_pause_pkg::RUN;
                end
            end
            default: begin
                state_next = axil_pause_pkg::RUN;
            end
        endcase
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            state     <= axil_pause_pkg::RUN;
            pause_ack <= 1'b0;
        end else begin
            state     <= state_next;
            pause_ack <= state_next == axil_pause_pkg::PAUSED; // tracks PAUSED exactly
        end
    end

    assign accept_en = state == axil_pause_pkg::RUN;

endmodule

// ==== hdl/axil_pause_gate.sv ====
`timescale 1ns/100ps

module axil_pause_gate (
    axil_if.target    up,
    axil_if.initiator dn,

    input  logic      accept_en,
    input  logic      write_room,
    input  logic      read_room,
    input  logic      w_owed
);

    logic aw_open;
    logic w_open;
    logic ar_open;

    assign aw_open = accept_en && write_room;
    assign w_open  = w_owed;
    assign ar_open = accept_en && read_room;

    // a closed channel shows neither valid downstream nor ready upstream,
    // so no beat can slip through on either side

    // write address
    assign dn.aw_addr  = up.aw_addr;
    assign dn.aw_prot  = up.aw_prot;
    assign dn.aw_valid = up.aw_valid && aw_open;
    assign up.aw_ready = dn.aw_ready && aw_open;

    // write data
    assign dn.w_data   = up.w_data;
    assign dn.w_strb   = up.w_strb;
    assign dn.w_valid  = up.w_valid && w_open;
    assign up.w_ready  = dn.w_ready && w_open;

    // write response is never held back
    assign up.b_resp   = dn.b_resp;
    assign up.b_valid  = dn.b_valid;
    assign dn.b_ready  = up.b_ready;

    // read address
    assign dn.ar_addr  = up.ar_addr;
    assign dn.ar_prot  = up.ar_prot;
    assign dn.ar_valid = up.ar_valid && ar_open;
    assign up.ar_ready = dn.ar_ready && ar_open;

    // read data is never held back either
    assign up.r_data   = dn.r_data;
    assign up.r_resp   = dn.r_resp;
    assign up.r_valid  = dn.r_valid;
    assign dn.r_ready  = up.r_ready;

endmodule

// ==== hdl/axil_pause_pkg.sv ====
`include "axil_pause_settings.svh"

package axil_pause_pkg;

    typedef logic [`AXIL_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`AXIL_DATA_WIDTH-1:0]   data_t;
    typedef logic [`AXIL_DATA_WIDTH/8-1:0] strb_t; // one strobe per data byte
    typedef logic [2:0]                    prot_t;
    typedef logic [1:0]                    resp_t;

    // outstanding counters, one bit of headroom over AXIL_MAX_TRANS
    typedef logic [3:0] cnt_t;

    typedef enum logic [1:0] {
        RUN,    // traffic flows, new addresses are accepted
        DRAIN,  // no new addresses, waiting for the link to empty
        PAUSED  // link empty and frozen, pause_ack high
    } pause_state_e;

endpackage

// ==== hdl/axil_pause_settings.svh ====
`ifndef AXIL_PAUSE_SETTINGS_SVH
`define AXIL_PAUSE_SETTINGS_SVH

// bus widths of the AXI-Lite link, fixed for the whole build
`define AXIL_ADDR_WIDTH 32
`define AXIL_DATA_WIDTH 32

// how many writes and how many reads may be in flight at once
`define AXIL_MAX_TRANS 7

`endif

// ==== hdl/axil_txn_tracker.sv ====
`timescale 1ns/100ps

`include "axil_pause_settings.svh"

module axil_txn_tracker (
    input  logic seq,
    input  logic rst_n,

    input  logic aw_fire,
    input  logic w_fire,
    input  logic b_fire,
    input  logic ar_fire,
    input  logic r_fire,

    output logic write_room,
    output logic read_room,
    output logic w_owed,
    output logic idle
);

    axil_pause_pkg::cnt_t write_cnt;
    axil_pause_pkg::cnt_t owed_cnt;
    axil_pause_pkg::cnt_t read_cnt;

    // an increment and a decrement on the same edge cancel out
    function automatic axil_pause_pkg::cnt_t step(
        input axil_pause_pkg::cnt_t cnt,
        input logic                 inc,
        input logic                 dec
    );
        axil_pause_pkg::cnt_t res;
        res = cnt;
        if (inc && !dec) begin
            res = cnt + axil_pause_pkg::cnt_t'(1);
        end else if (dec && !inc) begin
            res = cnt - axil_pause_pkg::cnt_t'(1);
        end
        return res;
    endfunction

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            write_cnt <= '0;
            owed_cnt  <= '0;
            read_cnt  <= '0;
        end else begin
            write_cnt <= step(write_cnt, aw_fire, b_fire); // open until B returns
            owed_cnt  <= step(owed_cnt, aw_fire, w_fire);
            read_cnt  <= step(read_cnt, ar_fire, r_fire);
        end
    end

    assign write_room = write_cnt < axil_pause_pkg::cnt_t'(`AXIL_MAX_TRANS);
    assign read_room  = read_cnt < axil_pause_pkg::cnt_t'(`AXIL_MAX_TRANS);

    // a W beat may only go once its address is already downstream
    assign w_owed = owed_cnt != '0;

    // the owed count never exceeds the write count, but checking all three
    // keeps idle independent of target behavior
    assign idle = (write_cnt == '0) && (owed_cnt == '0) && (read_cnt == '0);

endmodule

// ==== list.f ====
+incdir+hdl
hdl/axil_pause_pkg.sv
hdl/axil_if.sv
hdl/axil_txn_tracker.sv
hdl/axil_pause_fsm.sv
hdl/axil_pause_gate.sv
hdl/axil_pause.sv
sim/axil_mem_target.sv
sim/axil_pause_tb.sv

// ==== sim/axil_mem_target.sv ====
`timescale 1ns/100ps

module axil_mem_target (
    input  logic                  seq,
    input  logic                  rst_n,
    input  logic                  stall,

    input  axil_pause_pkg::addr_t aw_addr,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axil_pause_pkg::data_t w_data,
    input  axil_pause_pkg::strb_t w_strb,
    input  logic                  w_valid,
    output logic                  w_ready,
    output axil_pause_pkg::resp_t b_resp,
    output logic                  b_valid,
    input  logic                  b_ready,
    input  axil_pause_pkg::addr_t ar_addr,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    output axil_pause_pkg::data_t r_data,
    output axil_pause_pkg::resp_t r_resp,
    output logic                  r_valid,
    input  logic                  r_ready
);

    axil_pause_pkg::data_t mem [64];
    logic [5:0]            aw_q [$];
    axil_pause_pkg::data_t w_q [$];
    axil_pause_pkg::strb_t s_q [$];
    logic [5:0]            ar_q [$];
    int                    b_owed;
    logic [31:0]           rnd = 32'h2110a6c8;

    logic                  aw_hit = 1'b0;
    logic                  w_hit = 1'b0;
    logic                  ar_hit = 1'b0;
    logic                  b_hit = 1'b0;
    logic                  r_hit = 1'b0;
    logic                  stall_s = 1'b0;
    logic [5:0]            aw_hit_addr;
    logic [5:0]            ar_hit_addr;
    axil_pause_pkg::data_t w_hit_data;
    axil_pause_pkg::strb_t w_hit_strb;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hc0de0000 ^ (i * 32'h00010203); // fill differs in every word
        end
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        ar_ready = 1'b0;
        b_valid  = 1'b0;
        r_valid  = 1'b0;
        b_resp   = '0;
        r_resp   = '0;
        r_data   = '0;
    end

    // handshakes are taken where the bus is stable and handled half a cycle later
    always @(posedge seq) begin
        aw_hit      = aw_valid && aw_ready;
        aw_hit_addr = aw_addr[7:2];
        w_hit       = w_valid && w_ready;
        w_hit_data  = w_data;
        w_hit_strb  = w_strb;
        ar_hit      = ar_valid && ar_ready;
        ar_hit_addr = ar_addr[7:2];
        b_hit       = b_valid && b_ready;
        r_hit       = r_valid && r_ready;
        stall_s     = stall;
    end

    always @(negedge seq or negedge rst_n) begin
        logic [5:0]            idx;
        axil_pause_pkg::data_t d;
        axil_pause_pkg::strb_t st;
        if (!rst_n) begin
            aw_q.delete();
            w_q.delete();
            s_q.delete();
            ar_q.delete();
            b_owed   = 0;
            aw_ready = 1'b0;
            w_ready  = 1'b0;
            ar_ready = 1'b0;
            b_valid  = 1'b0;
            r_valid  = 1'b0;
        end else begin
            rnd = xorshift32(rnd);
            if (aw_hit) aw_q.push_back(aw_hit_addr);
            if (w_hit) begin
                w_q.push_back(w_hit_data);
                s_q.push_back(w_hit_strb);
            end
            if (ar_hit) ar_q.push_back(ar_hit_addr);
            // a write lands once both its address and its data are here
            while (aw_q.size() != 0 && w_q.size() != 0) begin
                idx = aw_q.pop_front();
                d   = w_q.pop_front();
                st  = s_q.pop_front();
                for (int i = 0; i < 4; i++) begin
                    if (st[i]) mem[idx][8*i +: 8] = d[8*i +: 8];
                end
                b_owed++;
            end
            if (b_hit) b_valid = 1'b0;
            if (!b_valid && b_owed != 0 && !stall_s && rnd[0]) begin
                b_valid = 1'b1;
                b_resp  = 2'b00;
                b_owed--;
            end
            if (r_hit) r_valid = 1'b0;
            if (!r_valid && ar_q.size() != 0 && !stall_s && rnd[1]) begin
                r_data  = mem[ar_q.pop_front()];
                r_resp  = 2'b00;
                r_valid = 1'b1;
            end
            aw_ready = rnd[2] | rnd[3]; // ready about three cycles in four
            w_ready  = rnd[4] | rnd[5];
            ar_ready = rnd[6] | rnd[7];
        end
    end

endmodule

// ==== sim/axil_pause_tb.sv ====
`timescale 1ns/100ps

`include "axil_pause_settings.svh"

module axil_pause_tb;

    localparam logic [31:0] SEED = 32'h2110a6c8;
    localparam int N_WRITES = 16 + 20 + 16 + 6;
    localparam int N_READS  = 16 + 20 + 52 + 58;
    localparam int N_PAUSES = 3;
    localparam int TIMEOUT  = 200 * (N_WRITES + N_READS) + 500 * N_PAUSES;

    logic seq;
    logic rst_n;
    logic pause_req;
    logic pause_ack;
    logic stall;
    logic pulse_mode;

    axil_pause_pkg::addr_t s_aw_addr, m_aw_addr, s_ar_addr, m_ar_addr;
    axil_pause_pkg::prot_t s_aw_prot, m_aw_prot, s_ar_prot, m_ar_prot;
    axil_pause_pkg::data_t s_w_data, m_w_data, s_r_data, m_r_data;
    axil_pause_pkg::strb_t s_w_strb, m_w_strb;
    axil_pause_pkg::resp_t s_b_resp, m_b_resp, s_r_resp, m_r_resp;
    logic s_aw_valid, s_aw_ready, s_w_valid, s_w_ready, s_b_valid, s_b_ready;
    logic s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
    logic m_aw_valid, m_aw_ready, m_w_valid, m_w_ready, m_b_valid, m_b_ready;
    logic m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;

    axil_pause_pkg::addr_t aw_q [$];
    axil_pause_pkg::data_t w_q [$];
    axil_pause_pkg::addr_t ar_q [$];
    axil_pause_pkg::data_t exp_q [$];
    logic [5:0]            used_q [$];
    axil_pause_pkg::data_t model [64];

    logic [31:0] stim_rnd;
    logic [31:0] gap_rnd;
    int w_issued, w_done;
    int wr_open, rd_open, aw_cnt, w_cnt;
    int errors, tests_run, tests_failed, mark;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    axil_pause i_axil_pause (.*);

    axil_mem_target i_target (
        .seq(seq), .rst_n(rst_n), .stall(stall),
        .aw_addr(m_aw_addr), .aw_valid(m_aw_valid), .aw_ready(m_aw_ready),
        .w_data(m_w_data), .w_strb(m_w_strb), .w_valid(m_w_valid), .w_ready(m_w_ready),
        .b_resp(m_b_resp), .b_valid(m_b_valid), .b_ready(m_b_ready),
        .ar_addr(m_ar_addr), .ar_valid(m_ar_valid), .ar_ready(m_ar_ready),
        .r_data(m_r_data), .r_resp(m_r_resp), .r_valid(m_r_valid), .r_ready(m_r_ready)
    );

    always #5 seq = ~seq;

    // upstream initiator, driven half a cycle away from the sampling edge
    always @(negedge seq) begin
        gap_rnd    = xorshift32(gap_rnd);
        s_b_ready  = gap_rnd[0] | gap_rnd[1];
        s_r_ready  = gap_rnd[2] | gap_rnd[3];
        s_aw_valid = rst_n && aw_q.size() != 0;
        s_w_valid  = rst_n && w_q.size() != 0;
        s_ar_valid = rst_n && ar_q.size() != 0;
        if (aw_q.size() != 0) begin
            s_aw_addr = aw_q[0];
            s_aw_prot = s_aw_addr[4:2]; // prot follows the address so it changes between beats
        end
        if (w_q.size() != 0) s_w_data = w_q[0];
        if (ar_q.size() != 0) begin
            s_ar_addr = ar_q[0];
            s_ar_prot = s_ar_addr[4:2];
        end
    end

    always @(posedge seq) begin
        axil_pause_pkg::data_t exp_data;
        if (rst_n) begin
            if (s_aw_valid && s_aw_ready) void'(aw_q.pop_front());
            if (s_w_valid && s_w_ready) void'(w_q.pop_front());
            if (s_ar_valid && s_ar_ready) void'(ar_q.pop_front());
            if (s_b_valid && s_b_ready) begin
                w_done++;
                assert (s_b_resp == 2'b00) else begin
                    $display("FAILED s_b_resp: got %h expected %h", s_b_resp, 2'b00);
                    errors++;
                end
            end
            if (s_r_valid && s_r_ready) begin
                if (exp_q.size() == 0) begin
                    $display("read response arrived with no read outstanding");
                    errors++;
                end else begin
                    exp_data = exp_q.pop_front();
                    assert (s_r_data == exp_data && s_r_resp == 2'b00) else begin
                        $display("FAILED s_r_data/s_r_resp: got %h/%h expected %h/%h",
                                 s_r_data, s_r_resp, exp_data, 2'b00);
                        errors++;
                    end
                end
            end
        end
    end

    // transfers as seen at the target side
    always @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            wr_open <= 0;
            rd_open <= 0;
            aw_cnt  <= 0;
            w_cnt   <= 0;
        end else begin
            wr_open <= wr_open + int'(m_aw_valid && m_aw_ready) - int'(m_b_valid && m_b_ready);
            rd_open <= rd_open + int'(m_ar_valid && m_ar_ready) - int'(m_r_valid && m_r_ready);
            aw_cnt  <= aw_cnt + int'(m_aw_valid && m_aw_ready);
            w_cnt   <= w_cnt + int'(m_w_valid && m_w_ready);
        end
    end

    assert property (@(posedge seq) (!rst_n || $rose(rst_n)) |-> !pause_ack && !s_b_valid
            && !s_r_valid && !m_aw_valid && !m_w_valid && !m_ar_valid) else begin
        $display("FAILED reset state: pause_ack=%h s_b_valid=%h s_r_valid=%h", pause_ack,
                 s_b_valid, s_r_valid);
        errors++;
    end

    assert property (@(posedge seq) disable iff (!rst_n)
            m_aw_valid |-> m_aw_prot == m_aw_addr[4:2]) else begin
        $display("FAILED m_aw_prot: got %h expected %h", m_aw_prot, m_aw_addr[4:2]);
        errors++;
    end

    assert property (@(posedge seq) disable iff (!rst_n)
            m_ar_valid |-> m_ar_prot == m_ar_addr[4:2]) else begin
        $display("FAILED m_ar_prot: got %h expected %h", m_ar_prot, m_ar_addr[4:2]);
        errors++;
    end

    assert property (@(posedge seq) disable iff (!rst_n)
            wr_open <= `AXIL_MAX_TRANS && rd_open <= `AXIL_MAX_TRANS) else begin
        $display("FAILED outstanding count: writes %h reads %h limit %h", wr_open, rd_open,
                 `AXIL_MAX_TRANS);
        errors++;
    end

    assert property (@(posedge seq) disable iff (!rst_n)
            m_w_valid && m_w_ready |-> aw_cnt > w_cnt) else begin
        $display("FAILED m_w_valid: beat with aw count %h and w count %h", aw_cnt, w_cnt);
        errors++;
    end

    assert property (@(posedge seq) disable iff (!rst_n)
            $rose(pause_ack) |-> wr_open == 0 && rd_open == 0) else begin
        $display("FAILED pause_ack rose with writes %h reads %h open", wr_open, rd_open);
        errors++;
    end

    assert property (@(posedge seq) disable iff (!rst_n)
            pause_ack |-> !m_aw_valid && !m_ar_valid) else begin
        $display("FAILED m_aw_valid=%h m_ar_valid=%h while paused", m_aw_valid, m_ar_valid);
        errors++;
    end

    assert property (@(posedge seq) disable iff (!rst_n)
            pause_ack && pause_req |=> pause_ack) else begin
        $display("FAILED pause_ack: got %h expected %h with pause_req held", pause_ack, 1'b1);
        errors++;
    end

    assert property (@(posedge seq) disable iff (!rst_n)
            $fell(pause_req) && pause_ack |=> !pause_ack) else begin
        $display("FAILED pause_ack: got %h expected %h after release", pause_ack, 1'b0);
        errors++;
    end

    assert property (@(posedge seq) disable iff (!rst_n) pulse_mode |-> !pause_ack) else begin
        $display("FAILED pause_ack: got %h expected %h for a dropped request", pause_ack, 1'b0);
        errors++;
    end

    task automatic write_batch(input int n);
        logic [5:0] idx;
        @(posedge seq);
        for (int i = 0; i < n; i++) begin
            stim_rnd = xorshift32(stim_rnd);
            idx = stim_rnd[5:0];
            stim_rnd = xorshift32(stim_rnd);
            model[idx] = stim_rnd;
            used_q.push_back(idx);
            aw_q.push_back(axil_pause_pkg::addr_t'({idx, 2'b00}));
            w_q.push_back(stim_rnd);
            w_issued++;
        end
    endtask

    task automatic read_word(input logic [5:0] idx);
        ar_q.push_back(axil_pause_pkg::addr_t'({idx, 2'b00}));
        exp_q.push_back(model[idx]);
    endtask

    task automatic read_batch_random(input int n);
        @(posedge seq);
        for (int i = 0; i < n; i++) begin
            stim_rnd = xorshift32(stim_rnd);
            read_word(used_q[stim_rnd % used_q.size()]);
        end
    endtask

    task automatic read_back_all();
        @(posedge seq);
        foreach (used_q[i]) read_word(used_q[i]);
    endtask

    task automatic wait_drained();
        while (aw_q.size() != 0 || w_q.size() != 0 || ar_q.size() != 0
               || w_issued != w_done || exp_q.size() != 0) begin
            @(posedge seq);
        end
        repeat (2) @(posedge seq);
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - err_start);
            tests_failed++;
        end
    endtask

    initial begin
        repeat (TIMEOUT) @(posedge seq);
        $display("timeout: the run took longer than %0d cycles", TIMEOUT);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        seq = 1'b0;
        rst_n = 1'b1;
        pause_req = 1'b0;
        stall = 1'b0;
        pulse_mode = 1'b0;
        s_aw_addr = '0;
        s_aw_prot = '0;
        s_aw_valid = 1'b0;
        s_w_data = '0;
        s_w_strb = '1;
        s_w_valid = 1'b0;
        s_b_ready = 1'b0;
        s_ar_addr = '0;
        s_ar_prot = '0;
        s_ar_valid = 1'b0;
        s_r_ready = 1'b0;
        stim_rnd = SEED;
        gap_rnd = xorshift32(SEED);
        w_issued = 0;
        w_done = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        #1 rst_n = 1'b0;
        repeat (2) @(negedge seq);
        rst_n = 1'b1;
        repeat (3) @(negedge seq);
        report_test("reset state", 0);

        mark = errors;
        write_batch(16);
        wait_drained();
        read_back_all();
        wait_drained();
        report_test("data integrity and write ordering", mark);

        mark = errors;
        @(negedge seq);
        stall = 1'b1; // target holds B back, writes pile up at the limit
        write_batch(20);
        repeat (60) @(negedge seq);
        assert (wr_open == `AXIL_MAX_TRANS) else begin
            $display("FAILED wr_open: got %h expected %h", wr_open, `AXIL_MAX_TRANS);
            errors++;
        end
        stall = 1'b0;
        wait_drained();
        @(negedge seq);
        stall = 1'b1;
        read_batch_random(20);
        repeat (60) @(negedge seq);
        assert (rd_open == `AXIL_MAX_TRANS) else begin
            $display("FAILED rd_open: got %h expected %h", rd_open, `AXIL_MAX_TRANS);
            errors++;
        end
        stall = 1'b0;
        wait_drained();
        report_test("outstanding limit", mark);

        mark = errors;
        write_batch(12);
        repeat (3) @(negedge seq);
        pause_req = 1'b1;
        while (!pause_ack) @(negedge seq);
        // writes still queued upstream were never accepted, all others must be done
        assert ((w_issued - w_done) == aw_q.size()) else begin
            $display("transactions accepted before the pause did not complete");
            errors++;
        end
        write_batch(4);
        repeat (20) @(negedge seq);
        pause_req = 1'b0;
        wait_drained();
        read_back_all();
        repeat (3) @(negedge seq);
        pause_req = 1'b1; // reads still queued upstream have to wait at the gate
        while (!pause_ack) @(negedge seq);
        assert (exp_q.size() == ar_q.size()) else begin
            $display("reads accepted before the pause did not complete");
            errors++;
        end
        repeat (20) @(negedge seq);
        pause_req = 1'b0;
        wait_drained();
        report_test("pause with traffic in flight", mark);

        mark = errors;
        @(negedge seq);
        stall = 1'b1;
        write_batch(6);
        while (wr_open == 0) @(negedge seq);
        pulse_mode = 1'b1;
        pause_req = 1'b1;
        repeat (2) @(negedge seq);
        pause_req = 1'b0;
        repeat (10) @(negedge seq);
        stall = 1'b0;
        wait_drained();
        pulse_mode = 1'b0;
        read_back_all();
        wait_drained();
        report_test("release after a dropped request", mark);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
